//--- Makefile
SRCS := $(wildcard verilog/*.sv) $(wildcard tests/*.sv)

.PHONY: run clean

obj_dir/Vdcache_tb: list.f $(SRCS)
	verilator --binary --timing -f list.f --top-module dcache_tb -o Vdcache_tb

run: obj_dir/Vdcache_tb
	./obj_dir/Vdcache_tb | tee sim.log
	grep -q "TEST RESULT: PASS" sim.log

clean:
	rm -rf obj_dir sim.log

//--- list.f
verilog/dcache_pkg.sv
verilog/dcache_tags.sv
verilog/dcache_data.sv
verilog/dcache_ctrl.sv
verilog/dcache_top.sv
tests/mem_model.sv
tests/dcache_tb.sv

//--- tests/dcache_tb.sv
`timescale 1ns/10ps
`default_nettype none

module dcache_tb;

    localparam int NUM_OPS = 20;
    localparam int TIMEOUT = 300;

    logic        clk;
    logic        rst;
    logic        req_valid;
    logic [31:0] req_addr;
    logic [3:0]  req_wstrb;
    logic [31:0] req_wdata;
    logic        req_ready;
    logic        rsp_valid;
    logic [31:0] rsp_rdata;
    logic        ar_valid;
    logic        ar_ready;
    logic [31:0] ar_addr;
    logic        r_valid;
    logic [31:0] r_data;
    logic        r_last;
    logic        aw_valid;
    logic        aw_ready;
    logic [31:0] aw_addr;
    logic        w_valid;
    logic        w_ready;
    logic [31:0] w_data;
    logic        w_last;
    logic        b_valid;

    // operation table
    string       op_name [NUM_OPS];
    logic [31:0] op_addr [NUM_OPS];
    logic [3:0]  op_strb [NUM_OPS];
    logic [31:0] op_wdata [NUM_OPS];
    logic [31:0] op_exp_data [NUM_OPS];
    int          op_exp_rd [NUM_OPS];
    int          op_exp_wr [NUM_OPS];
    int          n_ops;

    // mirror of memory and cache state
    logic [31:0]                  g_mem [logic [29:0]];
    bit [dcache_pkg::TAG_W-1:0]   m_tag [2][dcache_pkg::SETS];
    bit                           m_valid [2][dcache_pkg::SETS];
    bit                           m_dirty [2][dcache_pkg::SETS];
    bit                           m_repl [dcache_pkg::SETS];

    int rd_bursts;
    int wr_bursts;
    int data_errors;
    int count_errors;
    int flag_errors;
    int timeout_errors;

    dcache_top UUT (
        .clk         (clk),
        .rst         (rst),
        .i_req_valid (req_valid),
        .i_req_addr  (req_addr),
        .i_req_wstrb (req_wstrb),
        .i_req_wdata (req_wdata),
        .o_req_ready (req_ready),
        .o_rsp_valid (rsp_valid),
        .o_rsp_rdata (rsp_rdata),
        .o_ar_valid  (ar_valid),
        .i_ar_ready  (ar_ready),
        .o_ar_addr   (ar_addr),
        .i_r_valid   (r_valid),
        .i_r_data    (r_data),
        .i_r_last    (r_last),
        .o_aw_valid  (aw_valid),
        .i_aw_ready  (aw_ready),
        .o_aw_addr   (aw_addr),
        .o_w_valid   (w_valid),
        .i_w_ready   (w_ready),
        .o_w_data    (w_data),
        .o_w_last    (w_last),
        .i_b_valid   (b_valid)
    );

    mem_model u_mem (
        .clk        (clk),
        .rst        (rst),
        .i_ar_valid (ar_valid),
        .o_ar_ready (ar_ready),
        .i_ar_addr  (ar_addr),
        .o_r_valid  (r_valid),
        .o_r_data   (r_data),
        .o_r_last   (r_last),
        .i_aw_valid (aw_valid),
        .o_aw_ready (aw_ready),
        .i_aw_addr  (aw_addr),
        .i_w_valid  (w_valid),
        .o_w_ready  (w_ready),
        .i_w_data   (w_data),
        .i_w_last   (w_last),
        .o_b_valid  (b_valid)
    );

    always #20 clk = ~clk;

    // burst handshakes
    always @(posedge clk) begin
        if (rst && ar_valid && ar_ready) begin
            rd_bursts++;
        end
        if (rst && aw_valid && aw_ready) begin
            wr_bursts++;
        end
    end

    task automatic check_word(input string name, input logic [dcache_pkg::DATA_W-1:0] exp,
                              input logic [dcache_pkg::DATA_W-1:0] act);
        if (act !== exp) begin
            $display("Fail %s: expected %08h, actual %08h", name, exp, act);
            data_errors++;
        end
    endtask

    task automatic check_count(input string name, input int exp, input int act);
        if (act != exp) begin
            $display("Fail %s: expected %0d, actual %0d", name, exp, act);
            count_errors++;
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("Fail %s: expected %b, actual %b", name, exp, act);
            flag_errors++;
        end
    endtask

    task automatic report_timeout(input string what);
        dcache_pkg::ctrl_state_t st;
        st = UUT.u_ctrl.state;
        $display("timeout while waiting for %s, controller in state %s", what, st.name());
        timeout_errors++;
    endtask

    function automatic logic [31:0] golden_word(input logic [31:0] addr);
        if (g_mem.exists(addr[31:2])) begin
            return g_mem[addr[31:2]];
        end
        return {addr[31:2], 2'b00};
    endfunction

    task automatic add_op(input string name, input logic [31:0] addr,
                          input logic [3:0] strb, input logic [31:0] wdata);
        op_name[n_ops]  = name;
        op_addr[n_ops]  = addr;
        op_strb[n_ops]  = strb;
        op_wdata[n_ops] = wdata;
        n_ops++;
    endtask

    // miss allocates the way not last used and writes back a dirty victim
    task automatic predict_op(input int i);
        dcache_pkg::cache_addr_t    a;
        logic [7:0]                 idx;
        logic [dcache_pkg::TAG_W-1:0] tag;
        int                         way;
        logic [31:0]                mask;
        logic [31:0]                old;
        a.word = op_addr[i];
        idx = a.f.index;
        tag = a.f.tag;
        op_exp_rd[i] = 0;
        op_exp_wr[i] = 0;
        if (m_valid[0][idx] && m_tag[0][idx] == tag) begin
            way = 0;
        end else if (m_valid[1][idx] && m_tag[1][idx] == tag) begin
            way = 1;
        end else begin
            way = m_repl[idx] ? 1 : 0;
            op_exp_rd[i] = 1;
            if (m_valid[way][idx] && m_dirty[way][idx]) begin
                op_exp_wr[i] = 1;
            end
            m_tag[way][idx]   = tag;
            m_valid[way][idx] = 1'b1;
            m_dirty[way][idx] = 1'b0;
        end
        m_repl[idx] = (way == 0);
        old = golden_word(op_addr[i]);
        if (op_strb[i] != 4'd0) begin
            mask = {{8{op_strb[i][3]}}, {8{op_strb[i][2]}}, {8{op_strb[i][1]}},
                    {8{op_strb[i][0]}}};
            g_mem[op_addr[i][31:2]] = (old & ~mask) | (op_wdata[i] & mask);
            m_dirty[way][idx] = 1'b1;
            op_exp_data[i] = '0;
        end else begin
            op_exp_data[i] = old;
        end
    endtask

    task automatic run_op(input int i);
        int          wait_cnt;
        int          lat;
        int          rd0;
        int          wr0;
        logic [31:0] rdata;
        @(posedge clk);
        #2;
        req_valid = 1'b1;
        req_addr  = op_addr[i];
        req_wstrb = op_strb[i];
        req_wdata = op_wdata[i];
        wait_cnt  = 0;
        while (!req_ready) begin
            wait_cnt++;
            if (wait_cnt > TIMEOUT) begin
                report_timeout("request ready");
                req_valid = 1'b0;
                return;
            end
            @(posedge clk);
            #2;
        end
        rd0 = rd_bursts;
        wr0 = wr_bursts;
        @(posedge clk);
        #2;
        req_valid = 1'b0;
        req_wstrb = '0;
        lat      = 1;
        wait_cnt = 0;
        while (!rsp_valid) begin
            wait_cnt++;
            if (wait_cnt > TIMEOUT) begin
                report_timeout("response");
                return;
            end
            @(posedge clk);
            #2;
            lat++;
        end
        rdata = rsp_rdata;
        check_word({op_name[i], " data"}, op_exp_data[i], rdata);
        check_count({op_name[i], " read bursts"}, op_exp_rd[i], rd_bursts - rd0);
        check_count({op_name[i], " write bursts"}, op_exp_wr[i], wr_bursts - wr0);
        if (op_exp_rd[i] == 0) begin
            check_count({op_name[i], " hit latency"}, 2, lat);
        end
    endtask

    initial begin
        clk            = 1'b0;
        rst            = 1'b0;
        req_valid      = 1'b0;
        req_addr       = '0;
        req_wstrb      = '0;
        req_wdata      = '0;
        rd_bursts      = 0;
        wr_bursts      = 0;
        data_errors    = 0;
        count_errors   = 0;
        flag_errors    = 0;
        timeout_errors = 0;
        n_ops          = 0;

        // set 5 covers hits, merges and dirty evictions
        add_op("read_miss",      32'h0000_0140, 4'b0000, 32'h0);
        add_op("read_hit",       32'h0000_0144, 4'b0000, 32'h0);
        add_op("write_hit_part", 32'h0000_0148, 4'b0101, 32'hAABB_CCDD);
        add_op("read_merged",    32'h0000_0148, 4'b0000, 32'h0);
        add_op("write_miss",     32'h0000_4148, 4'b1111, 32'h1234_5678);
        add_op("read_wr_miss",   32'h0000_4148, 4'b0000, 32'h0);
        add_op("evict_dirty",    32'h0000_8140, 4'b0000, 32'h0);
        add_op("reread_evicted", 32'h0000_0148, 4'b0000, 32'h0);
        add_op("reread_second",  32'h0000_4148, 4'b0000, 32'h0);
        // set 9 shows which way gets replaced
        add_op("fill_way0",      32'h0000_0240, 4'b0000, 32'h0);
        add_op("fill_way1",      32'h0000_4240, 4'b0000, 32'h0);
        add_op("touch_way0",     32'h0000_0244, 4'b0000, 32'h0);
        add_op("evict_way1",     32'h0000_8240, 4'b0000, 32'h0);
        add_op("way0_kept",      32'h0000_024C, 4'b0000, 32'h0);
        add_op("way1_gone",      32'h0000_4248, 4'b0000, 32'h0);
        add_op("write_hit_full", 32'h0000_8244, 4'b1111, 32'hCAFE_0001);
        add_op("read_full",      32'h0000_8244, 4'b0000, 32'h0);

        for (int i = 0; i < n_ops; i++) begin
            predict_op(i);
        end

        repeat (3) @(posedge clk);
        #2;
        rst = 1'b1;

        check_flag("reset req_ready", 1'b1, req_ready);
        check_flag("reset rsp_valid", 1'b0, rsp_valid);
        check_flag("reset ar_valid", 1'b0, ar_valid);
        check_flag("reset aw_valid", 1'b0, aw_valid);
        check_flag("reset w_valid", 1'b0, w_valid);

        for (int i = 0; i < n_ops && timeout_errors == 0; i++) begin
            run_op(i);
        end

        repeat (2) @(posedge clk);
        $display("errors: data %0d, counts %0d, flags %0d, timeouts %0d",
                 data_errors, count_errors, flag_errors, timeout_errors);
        if (data_errors + count_errors + flag_errors + timeout_errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- tests/mem_model.sv
`timescale 1ns/10ps
`default_nettype none

module mem_model (
    input  wire         clk,
    input  wire         rst,
    input  wire         i_ar_valid,
    output logic        o_ar_ready,
    input  wire  [31:0] i_ar_addr,
    output logic        o_r_valid,
    output logic [31:0] o_r_data,
    output logic        o_r_last,
    input  wire         i_aw_valid,
    output logic        o_aw_ready,
    input  wire  [31:0] i_aw_addr,
    input  wire         i_w_valid,
    output logic        o_w_ready,
    input  wire  [31:0] i_w_data,
    input  wire         i_w_last,
    output logic        o_b_valid
);

    localparam logic [15:0] SEED = 16'd27;

    // sparse store, untouched words read back as their own byte address
    logic [31:0] mem [logic [29:0]];
    logic [15:0] lfsr;

    logic [1:0]  ar_wait;
    logic [1:0]  aw_wait;
    logic [1:0]  w_wait;
    logic        rd_active;
    logic [31:0] rd_addr;
    logic [3:0]  rd_beat;
    logic [31:0] wr_addr;
    logic [3:0]  wr_beat;

    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    function automatic logic [31:0] read_word(input logic [31:0] addr);
        if (mem.exists(addr[31:2])) begin
            return mem[addr[31:2]];
        end
        return {addr[31:2], 2'b00};
    endfunction

    // two lfsr bits give a stall of 0 to 3 cycles
    task automatic draw_stall(output logic [1:0] d);
        d[0] = lfsr[0];
        lfsr = lfsr_next(lfsr);
        d[1] = lfsr[0];
        lfsr = lfsr_next(lfsr);
    endtask

    always @(posedge clk) begin
        logic [1:0] d;
        if (!rst) begin
            lfsr = SEED;
            o_ar_ready <= 1'b0;
            o_aw_ready <= 1'b0;
            o_w_ready  <= 1'b0;
            o_r_valid  <= 1'b0;
            o_r_data   <= '0;
            o_r_last   <= 1'b0;
            o_b_valid  <= 1'b0;
            ar_wait    <= 2'd1;
            aw_wait    <= 2'd1;
            w_wait     <= 2'd1;
            rd_active  <= 1'b0;
            rd_addr    <= '0;
            rd_beat    <= '0;
            wr_addr    <= '0;
            wr_beat    <= '0;
        end else begin
            if (o_ar_ready && i_ar_valid) begin
                o_ar_ready <= 1'b0;
                draw_stall(d);
                ar_wait   <= d;
                rd_active <= 1'b1;
                rd_addr   <= i_ar_addr;
                rd_beat   <= '0;
            end else if (i_ar_valid) begin
                if (ar_wait == 2'd0) begin
                    o_ar_ready <= 1'b1;
                end else begin
                    ar_wait <= ar_wait - 2'd1;
                end
            end

            // read beats back to back, always accepted
            o_r_valid <= rd_active;
            o_r_last  <= rd_active && (rd_beat == 4'd15);
            if (rd_active) begin
                o_r_data <= read_word(rd_addr + {26'd0, rd_beat, 2'b00});
                rd_beat  <= rd_beat + 4'd1;
                if (rd_beat == 4'd15) begin
                    rd_active <= 1'b0;
                end
            end

            if (o_aw_ready && i_aw_valid) begin
                o_aw_ready <= 1'b0;
                draw_stall(d);
                aw_wait <= d;
                wr_addr <= i_aw_addr;
                wr_beat <= '0;
            end else if (i_aw_valid) begin
                if (aw_wait == 2'd0) begin
                    o_aw_ready <= 1'b1;
                end else begin
                    aw_wait <= aw_wait - 2'd1;
                end
            end

            if (o_w_ready && i_w_valid) begin
                mem[wr_addr[31:2] + {26'd0, wr_beat}] = i_w_data;
                wr_beat   <= wr_beat + 4'd1;
                o_w_ready <= 1'b0;
                draw_stall(d);
                w_wait <= d;
            end else if (i_w_valid) begin
                if (w_wait == 2'd0) begin
                    o_w_ready <= 1'b1;
                end else begin
                    w_wait <= w_wait - 2'd1;
                end
            end

            o_b_valid <= o_w_ready && i_w_valid && i_w_last;
        end
    end

endmodule

`default_nettype wire

//--- verilog/dcache_ctrl.sv
`timescale 1ns/10ps
`default_nettype none

module dcache_ctrl (
    input  wire                                              clk,
    input  wire                                              rst,
    input  wire                                              i_req_valid,
    input  wire  [dcache_pkg::ADDR_W-1:0]                    i_req_addr,
    input  wire  [dcache_pkg::STRB_W-1:0]                    i_req_wstrb,
    input  wire  [dcache_pkg::DATA_W-1:0]                    i_req_wdata,
    output logic                                             o_req_ready,
    output logic                                             o_rsp_valid,
    output logic [dcache_pkg::DATA_W-1:0]                    o_rsp_rdata,
    output logic                                             o_ar_valid,
    input  wire                                              i_ar_ready,
    output logic [dcache_pkg::ADDR_W-1:0]                    o_ar_addr,
    input  wire                                              i_r_valid,
    input  wire  [dcache_pkg::DATA_W-1:0]                    i_r_data,
    input  wire                                              i_r_last,
    output logic                                             o_aw_valid,
    input  wire                                              i_aw_ready,
    output logic [dcache_pkg::ADDR_W-1:0]                    o_aw_addr,
    output logic                                             o_w_valid,
    input  wire                                              i_w_ready,
    output logic [dcache_pkg::DATA_W-1:0]                    o_w_data,
    output logic                                             o_w_last,
    input  wire                                              i_b_valid,
    output logic                                             o_tag_lookup,
    output dcache_pkg::cache_addr_t                          o_tag_addr,
    output logic                                             o_tag_fill,
    output logic                                             o_fill_way,
    output logic                                             o_mark_dirty,
    output logic                                             o_dirty_way,
    output logic                                             o_touch,
    output logic                                             o_touch_way,
    input  wire                                              i_hit,
    input  wire                                              i_hit_way,
    input  wire                                              i_victim_way,
    input  wire                                              i_victim_dirty,
    input  wire  [dcache_pkg::TAG_W-1:0]                     i_victim_tag,
    output logic                                             o_data_en,
    output logic                                             o_data_way,
    output logic [dcache_pkg::INDEX_W+dcache_pkg::OFFSET_W-1:0] o_data_word_addr,
    output logic [dcache_pkg::STRB_W-1:0]                    o_data_wstrb,
    output logic [dcache_pkg::DATA_W-1:0]                    o_data_wdata,
    input  wire  [dcache_pkg::DATA_W-1:0]                    i_data_rdata
);

    dcache_pkg::ctrl_state_t state;
    dcache_pkg::ctrl_state_t next_state;

    dcache_pkg::cache_addr_t         cur_addr;
    dcache_pkg::cache_addr_t         req_addr;
    logic [dcache_pkg::STRB_W-1:0]   req_wstrb;
    logic [dcache_pkg::DATA_W-1:0]   req_wdata;
    logic [dcache_pkg::OFFSET_W-1:0] beat_cnt;
    logic                            req_write;

    assign cur_addr.word = i_req_addr;
    assign req_write     = |req_wstrb;

    assign o_req_ready = (state == dcache_pkg::IDLE);
    assign o_rsp_valid = (state == dcache_pkg::HIT_DONE);
    assign o_rsp_rdata = req_write ? '0 : i_data_rdata;

    // line-aligned burst addresses
    assign o_ar_valid = (state == dcache_pkg::FILL_ADDR);
    assign o_ar_addr  = {req_addr.f.tag, req_addr.f.index, 6'b0};
    assign o_aw_valid = (state == dcache_pkg::WB_ADDR);
    assign o_aw_addr  = {i_victim_tag, req_addr.f.index, 6'b0};
    assign o_w_valid  = (state == dcache_pkg::WB_DATA);
    assign o_w_data   = i_data_rdata;
    assign o_w_last   = (beat_cnt == '1);

    assign o_tag_lookup = ((state == dcache_pkg::IDLE) && i_req_valid)
                        || (state == dcache_pkg::FILL_DONE);
    assign o_tag_addr   = (state == dcache_pkg::IDLE) ? cur_addr : req_addr;
    assign o_tag_fill   = (state == dcache_pkg::FILL_DATA) && i_r_valid && i_r_last;
    assign o_fill_way   = i_victim_way;
    assign o_touch      = (state == dcache_pkg::LOOKUP) && i_hit;
    assign o_touch_way  = i_hit_way;
    assign o_mark_dirty = o_touch && req_write;
    assign o_dirty_way  = i_hit_way;

    always_comb begin
        o_data_en        = 1'b0;
        o_data_way       = i_victim_way;
        o_data_word_addr = {req_addr.f.index, req_addr.f.offset};
        o_data_wstrb     = '0;
        o_data_wdata     = req_wdata;
        case (state)
            dcache_pkg::LOOKUP: begin
                o_data_en    = i_hit;
                o_data_way   = i_hit_way;
                o_data_wstrb = req_wstrb;
            end
            // fetch word 0 as the address is accepted
            dcache_pkg::WB_ADDR: begin
                o_data_en        = i_aw_ready;
                o_data_word_addr = {req_addr.f.index, {dcache_pkg::OFFSET_W{1'b0}}};
            end
            // one word ahead of the beat on the bus
            dcache_pkg::WB_DATA: begin
                o_data_en        = i_w_ready && (beat_cnt != '1);
                o_data_word_addr = {req_addr.f.index, beat_cnt + 1'b1};
            end
            dcache_pkg::FILL_DATA: begin
                o_data_en        = i_r_valid;
                o_data_word_addr = {req_addr.f.index, beat_cnt};
                o_data_wstrb     = '1;
                o_data_wdata     = i_r_data;
            end
            default: begin
                o_data_en = 1'b0;
            end
        endcase
    end

    always_comb begin
        next_state = state;
        case (state)
            dcache_pkg::IDLE:
                if (i_req_valid) next_state = dcache_pkg::LOOKUP;
            dcache_pkg::LOOKUP:
                if (i_hit) next_state = dcache_pkg::HIT_DONE;
                else if (i_victim_dirty) next_state = dcache_pkg::WB_ADDR;
                else next_state = dcache_pkg::FILL_ADDR;
            dcache_pkg::HIT_DONE:
                next_state = dcache_pkg::IDLE;
            dcache_pkg::WB_ADDR:
                if (i_aw_ready) next_state = dcache_pkg::WB_DATA;
            dcache_pkg::WB_DATA:
                if (i_w_ready && (beat_cnt == '1)) next_state = dcache_pkg::WB_RESP;
            dcache_pkg::WB_RESP:
                if (i_b_valid) next_state = dcache_pkg::FILL_ADDR;
            dcache_pkg::FILL_ADDR:
                if (i_ar_ready) next_state = dcache_pkg::FILL_DATA;
            dcache_pkg::FILL_DATA:
                if (i_r_valid && i_r_last) next_state = dcache_pkg::FILL_DONE;
            // relookup so the request completes as a hit
            dcache_pkg::FILL_DONE:
                next_state = dcache_pkg::LOOKUP;
            default:
                next_state = dcache_pkg::IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            state    <= dcache_pkg::IDLE;
            beat_cnt <= '0;
        end else begin
            state <= next_state;
            if (state == dcache_pkg::LOOKUP) begin
                beat_cnt <= '0;
            end else if ((state == dcache_pkg::WB_DATA) && i_w_ready) begin
                beat_cnt <= beat_cnt + 1'b1;
            end else if ((state == dcache_pkg::FILL_DATA) && i_r_valid) begin
                beat_cnt <= beat_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (i_req_valid && o_req_ready) begin
            req_addr  <= cur_addr;
            req_wstrb <= i_req_wstrb;
            req_wdata <= i_req_wdata;
        end
    end

endmodule

`default_nettype wire

//--- verilog/dcache_data.sv
`timescale 1ns/10ps
`default_nettype none

module dcache_data (
    input  wire                                              clk,
    input  wire                                              i_en,
    input  wire                                              i_way,
    input  wire  [dcache_pkg::INDEX_W+dcache_pkg::OFFSET_W-1:0] i_word_addr,
    input  wire  [dcache_pkg::STRB_W-1:0]                    i_wstrb,
    input  wire  [dcache_pkg::DATA_W-1:0]                    i_wdata,
    output logic [dcache_pkg::DATA_W-1:0]                    o_rdata
);

    logic [dcache_pkg::DATA_W-1:0] mem [dcache_pkg::WAYS][dcache_pkg::SETS*dcache_pkg::LINE_WORDS];

    always_ff @(posedge clk) begin
        if (i_en) begin
            for (int b = 0; b < dcache_pkg::STRB_W; b++) begin
                if (i_wstrb[b]) begin
                    mem[i_way][i_word_addr][b*8 +: 8] <= i_wdata[b*8 +: 8];
                end
            end
        end
    end

    // output holds while not enabled, writeback relies on it
    always_ff @(posedge clk) begin
        if (i_en) begin
            o_rdata <= mem[i_way][i_word_addr];
        end
    end

endmodule

`default_nettype wire

//--- verilog/dcache_pkg.sv
`default_nettype none

package dcache_pkg;

    localparam int ADDR_W     = 32;
    localparam int TAG_W      = 18;
    localparam int INDEX_W    = 8;
    localparam int OFFSET_W   = 4;
    localparam int SETS       = 256;
    localparam int LINE_WORDS = 16;
    localparam int WAYS       = 2;
    localparam int STRB_W     = 4;
    localparam int DATA_W     = 32;

    typedef struct packed {
        logic [TAG_W-1:0]    tag;
        logic [INDEX_W-1:0]  index;
        logic [OFFSET_W-1:0] offset;
        logic [1:0]          byte_off;
    } addr_fields_t;

    // flat bus address or its cache fields
    typedef union packed {
        logic [ADDR_W-1:0] word;
        addr_fields_t      f;
    } cache_addr_t;

    typedef enum logic [3:0] {
        IDLE, LOOKUP, HIT_DONE,
        WB_ADDR, WB_DATA, WB_RESP,
        FILL_ADDR, FILL_DATA, FILL_DONE
    } ctrl_state_t;

endpackage

`default_nettype wire

//--- verilog/dcache_tags.sv
`timescale 1ns/10ps
`default_nettype none

module dcache_tags (
    input  wire                         clk,
    input  wire                         rst,
    input  wire                         i_lookup,
    input  dcache_pkg::cache_addr_t     i_addr,
    input  wire                         i_fill,
    input  wire                         i_fill_way,
    input  wire                         i_mark_dirty,
    input  wire                         i_dirty_way,
    input  wire                         i_touch,
    input  wire                         i_touch_way,
    output logic                        o_hit,
    output logic                        o_hit_way,
    output logic                        o_victim_way,
    output logic                        o_victim_dirty,
    output logic [dcache_pkg::TAG_W-1:0] o_victim_tag
);

    logic [dcache_pkg::TAG_W-1:0] tag_mem [dcache_pkg::WAYS][dcache_pkg::SETS];
    logic [dcache_pkg::SETS-1:0]  valid [dcache_pkg::WAYS];
    logic [dcache_pkg::SETS-1:0]  dirty [dcache_pkg::WAYS];
    // points at the way to replace next
    logic [dcache_pkg::SETS-1:0]  repl;

    logic [dcache_pkg::INDEX_W-1:0] idx;
    logic                           hit0;
    logic                           hit1;

    assign idx  = i_addr.f.index;
    assign hit0 = valid[0][idx] && (tag_mem[0][idx] == i_addr.f.tag);
    assign hit1 = valid[1][idx] && (tag_mem[1][idx] == i_addr.f.tag);

    always_ff @(posedge clk) begin
        if (i_fill) begin
            tag_mem[i_fill_way][idx] <= i_addr.f.tag;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            for (int w = 0; w < dcache_pkg::WAYS; w++) begin
                valid[w] <= '0;
                dirty[w] <= '0;
            end
            repl <= '0;
        end else begin
            if (i_fill) begin
                valid[i_fill_way][idx] <= 1'b1;
                dirty[i_fill_way][idx] <= 1'b0;
            end
            if (i_mark_dirty) begin
                dirty[i_dirty_way][idx] <= 1'b1;
            end
            if (i_touch) begin
                repl[idx] <= ~i_touch_way;
            end
        end
    end

    // lookup result, held until the next lookup
    always_ff @(posedge clk) begin
        if (!rst) begin
            o_hit          <= 1'b0;
            o_hit_way      <= 1'b0;
            o_victim_way   <= 1'b0;
            o_victim_dirty <= 1'b0;
            o_victim_tag   <= '0;
        end else if (i_lookup) begin
            o_hit          <= hit0 || hit1;
            o_hit_way      <= hit1;
            o_victim_way   <= repl[idx];
            o_victim_dirty <= valid[repl[idx]][idx] && dirty[repl[idx]][idx];
            o_victim_tag   <= tag_mem[repl[idx]][idx];
        end
    end

endmodule

`default_nettype wire

//--- verilog/dcache_top.sv
`timescale 1ns/10ps
`default_nettype none

module dcache_top (
    input  wire                            clk,
    input  wire                            rst,
    input  wire                            i_req_valid,
    input  wire  [dcache_pkg::ADDR_W-1:0]  i_req_addr,
    input  wire  [dcache_pkg::STRB_W-1:0]  i_req_wstrb,
    input  wire  [dcache_pkg::DATA_W-1:0]  i_req_wdata,
    output logic                           o_req_ready,
    output logic                           o_rsp_valid,
    output logic [dcache_pkg::DATA_W-1:0]  o_rsp_rdata,
    output logic                           o_ar_valid,
    input  wire                            i_ar_ready,
    output logic [dcache_pkg::ADDR_W-1:0]  o_ar_addr,
    input  wire                            i_r_valid,
    input  wire  [dcache_pkg::DATA_W-1:0]  i_r_data,
    input  wire                            i_r_last,
    output logic                           o_aw_valid,
    input  wire                            i_aw_ready,
    output logic [dcache_pkg::ADDR_W-1:0]  o_aw_addr,
    output logic                           o_w_valid,
    input  wire                            i_w_ready,
    output logic [dcache_pkg::DATA_W-1:0]  o_w_data,
    output logic                           o_w_last,
    input  wire                            i_b_valid
);

    logic                                               tag_lookup;
    dcache_pkg::cache_addr_t                            tag_addr;
    logic                                               tag_fill;
    logic                                               fill_way;
    logic                                               mark_dirty;
    logic                                               dirty_way;
    logic                                               touch;
    logic                                               touch_way;
    logic                                               hit;
    logic                                               hit_way;
    logic                                               victim_way;
    logic                                               victim_dirty;
    logic [dcache_pkg::TAG_W-1:0]                       victim_tag;
    logic                                               data_en;
    logic                                               data_way;
    logic [dcache_pkg::INDEX_W+dcache_pkg::OFFSET_W-1:0] data_word_addr;
    logic [dcache_pkg::STRB_W-1:0]                      data_wstrb;
    logic [dcache_pkg::DATA_W-1:0]                      data_wdata;
    logic [dcache_pkg::DATA_W-1:0]                      data_rdata;

    dcache_tags u_tags (
        .clk            (clk),
        .rst            (rst),
        .i_lookup       (tag_lookup),
        .i_addr         (tag_addr),
        .i_fill         (tag_fill),
        .i_fill_way     (fill_way),
        .i_mark_dirty   (mark_dirty),
        .i_dirty_way    (dirty_way),
        .i_touch        (touch),
        .i_touch_way    (touch_way),
        .o_hit          (hit),
        .o_hit_way      (hit_way),
        .o_victim_way   (victim_way),
        .o_victim_dirty (victim_dirty),
        .o_victim_tag   (victim_tag)
    );

    dcache_data u_data (
        .clk         (clk),
        .i_en        (data_en),
        .i_way       (data_way),
        .i_word_addr (data_word_addr),
        .i_wstrb     (data_wstrb),
        .i_wdata     (data_wdata),
        .o_rdata     (data_rdata)
    );

    dcache_ctrl u_ctrl (
        .clk              (clk),
        .rst              (rst),
        .i_req_valid      (i_req_valid),
        .i_req_addr       (i_req_addr),
        .i_req_wstrb      (i_req_wstrb),
        .i_req_wdata      (i_req_wdata),
        .o_req_ready      (o_req_ready),
        .o_rsp_valid      (o_rsp_valid),
        .o_rsp_rdata      (o_rsp_rdata),
        .o_ar_valid       (o_ar_valid),
        .i_ar_ready       (i_ar_ready),
        .o_ar_addr        (o_ar_addr),
        .i_r_valid        (i_r_valid),
        .i_r_data         (i_r_data),
        .i_r_last         (i_r_last),
        .o_aw_valid       (o_aw_valid),
        .i_aw_ready       (i_aw_ready),
        .o_aw_addr        (o_aw_addr),
        .o_w_valid        (o_w_valid),
        .i_w_ready        (i_w_ready),
        .o_w_data         (o_w_data),
        .o_w_last         (o_w_last),
        .i_b_valid        (i_b_valid),
        .o_tag_lookup     (tag_lookup),
        .o_tag_addr       (tag_addr),
        .o_tag_fill       (tag_fill),
        .o_fill_way       (fill_way),
        .o_mark_dirty     (mark_dirty),
        .o_dirty_way      (dirty_way),
        .o_touch          (touch),
        .o_touch_way      (touch_way),
        .i_hit            (hit),
        .i_hit_way        (hit_way),
        .i_victim_way     (victim_way),
        .i_victim_dirty   (victim_dirty),
        .i_victim_tag     (victim_tag),
        .o_data_en        (data_en),
        .o_data_way       (data_way),
        .o_data_word_addr (data_word_addr),
        .o_data_wstrb     (data_wstrb),
        .o_data_wdata     (data_wdata),
        .i_data_rdata     (data_rdata)
    );

endmodule

`default_nettype wire
